//--- hw/core_fetch_pkg.sv
// Fetch-side constants for the front end. The shift structure of the buffer
// assumes 8-byte reads and a 12-byte store; these values are not free to change.
package core_fetch_pkg;

    // ----------------------------------------
    // Addresses.
    // ----------------------------------------

    typedef logic [31:0] core_addr_t; // Byte address.

    // Fetch restart point after reset, halfword aligned.
    localparam core_addr_t RESET_PC = 32'h0000_0000;

    // ----------------------------------------
    // Memory and buffer geometry.
    // ----------------------------------------

    localparam int unsigned FETCH_BYTES = 8;    // Bytes per memory read.
    localparam int unsigned FBUF_BYTES  = 12;   // Buffer capacity in bytes.
    localparam int unsigned FBUF_DEPTH_W = 5;   // Depth count width, holds 0..12.

    // Top bit of the buffer head window, two halfwords.
    localparam int unsigned FD_IBUF_R = 31;

    // Top bit of the head error tags, one per halfword.
    localparam int unsigned FD_ERR_R = 1;

    // A read may go out only if next-cycle depth leaves room for a full
    // 8-byte response, so 12 - 8.
    localparam int unsigned FILL_ROOM = 4;

endpackage

//--- hw/core_instr_pkg.sv
// Instruction-side types. Only the length is decoded; the RVC rule is that
// low opcode bits of 11 mark a 32-bit instruction, anything else is 16-bit.
package core_instr_pkg;

    // ----------------------------------------
    // Instruction word.
    // ----------------------------------------

    // 16-bit instructions are zero-extended into this.
    typedef logic [31:0] instr_t;

    // ----------------------------------------
    // Length encoding.
    // ----------------------------------------

    typedef enum logic {
        ILEN_16 = 1'b0, // Compressed.
        ILEN_32 = 1'b1  // Full width.
    } ilen_t;

    // Low two opcode bits of a full-width instruction.
    localparam logic [1:0] RVC_FULL_OP = 2'b11;

endpackage

//--- hw/core_pipe_fetch_req.sv
// Fetch request stage. Memory must answer exactly one cycle after mem_req.
// Only the first read after a redirect or reset is trimmed by the target offset.
`timescale 1ns/1ps

module core_pipe_fetch_req (
    input  logic                                          g_clk,
    input  logic                                          g_resetn,
    input  logic                                          redirect,    // Restart pulse.
    input  core_fetch_pkg::core_addr_t                    redirect_pc, // Restart target.
    input  logic [core_fetch_pkg::FBUF_DEPTH_W-1:0]       n_depth,     // Next buffer depth.
    output logic                                          mem_req,
    output core_fetch_pkg::core_addr_t                    mem_addr,
    input  logic                                          mem_rvalid,
    input  logic                                          mem_rerr,
    input  logic [8*core_fetch_pkg::FETCH_BYTES-1:0]      mem_rdata,
    output logic                                          fill_en,
    output logic                                          fill_2,
    output logic                                          fill_4,
    output logic                                          fill_6,
    output logic                                          fill_8,
    output logic                                          error_in,
    output logic [8*core_fetch_pkg::FETCH_BYTES-1:0]      data_in
);

    logic                       run_q;      // Low only until the release edge.
    logic                       inflight_q; // A read went out last cycle.
    logic [1:0]                 off_q;      // Halfword offset for the next read.
    logic [1:0]                 rsp_off_q;  // Offset that belongs to the response.
    core_fetch_pkg::core_addr_t addr_q;     // Next aligned fetch address.
    logic                       take_rsp;

    // ----------------------------------------
    // Request side.
    // ----------------------------------------

    // No read in a redirect cycle, so nothing stale can come back after it.
    assign mem_req  = run_q && !redirect && (n_depth <= core_fetch_pkg::FILL_ROOM);
    assign mem_addr = addr_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            run_q      <= 1'b0;
            inflight_q <= 1'b0;
            addr_q     <= {core_fetch_pkg::RESET_PC[31:3], 3'b000}; // Reset acts as redirect.
            off_q      <= core_fetch_pkg::RESET_PC[2:1];
            rsp_off_q  <= 2'd0;
        end else begin
            run_q      <= 1'b1;
            inflight_q <= mem_req;
            if (redirect) begin
                addr_q <= {redirect_pc[31:3], 3'b000};
                off_q  <= redirect_pc[2:1];
            end else if (mem_req) begin
                addr_q    <= addr_q + core_fetch_pkg::FETCH_BYTES;
                off_q     <= 2'd0;  // Later reads are whole words.
                rsp_off_q <= off_q;
            end
        end
    end

    // ----------------------------------------
    // Response side.
    // ----------------------------------------

    // A response in a redirect cycle is discarded; the buffer flushes anyway.
    assign take_rsp = mem_rvalid && inflight_q && !redirect;
    assign fill_en  = take_rsp;

    // Remaining byte count picks the strobe.
    assign fill_8 = take_rsp && (rsp_off_q == 2'd0);
    assign fill_6 = take_rsp && (rsp_off_q == 2'd1);
    assign fill_4 = take_rsp && (rsp_off_q == 2'd2);
    assign fill_2 = take_rsp && (rsp_off_q == 2'd3);

    assign data_in  = mem_rdata >> {rsp_off_q, 4'b0000}; // Drop skipped halfwords.
    assign error_in = take_rsp && mem_rerr;

    // Memory latency is fixed at one cycle.
    a_rvalid_latency: assert property (@(posedge g_clk) disable iff (!g_resetn)
        mem_rvalid |-> $past(mem_req));

endmodule

//--- hw/core_pipe_fetch_buffer.sv
// Fetch shift buffer. Takes 0, 2, 4, 6 or 8 low-aligned bytes and drains 0, 2
// or 4 per cycle. The caller must never fill past 12 bytes or drain past depth.
`timescale 1ns/1ps

module core_pipe_fetch_buffer (
    input  logic                                          g_clk,
    input  logic                                          g_resetn,
    input  logic                                          flush,     // Drop all content.
    output logic [core_fetch_pkg::FBUF_DEPTH_W-1:0]       depth,     // Bytes held now.
    output logic [core_fetch_pkg::FBUF_DEPTH_W-1:0]       n_depth,   // Bytes held next cycle.
    input  logic                                          fill_en,
    input  logic                                          error_in,  // Tag for the fill.
    input  logic                                          fill_2,
    input  logic                                          fill_4,
    input  logic                                          fill_6,
    input  logic                                          fill_8,
    input  logic [8*core_fetch_pkg::FETCH_BYTES-1:0]      data_in,
    output logic [core_fetch_pkg::FD_IBUF_R:0]            data_out,  // Head halfwords.
    output logic [core_fetch_pkg::FD_ERR_R:0]             error_out, // Head error tags.
    input  logic                                          drain_2,
    input  logic                                          drain_4
);

    // Byte 0 is the buffer head. Bytes above depth read as zero.
    logic [8*core_fetch_pkg::FBUF_BYTES-1:0]    d_buf;
    logic [core_fetch_pkg::FBUF_BYTES/2-1:0]    e_buf;      // One tag per halfword.

    logic [core_fetch_pkg::FBUF_DEPTH_W-1:0]    fill_bytes;
    logic [core_fetch_pkg::FBUF_DEPTH_W-1:0]    drain_bytes;
    logic [core_fetch_pkg::FBUF_DEPTH_W-1:0]    shf_up;     // Where new bytes land.
    logic [8*core_fetch_pkg::FBUF_BYTES-1:0]    fill_data;
    logic [8*core_fetch_pkg::FBUF_BYTES-1:0]    n_d_buf;
    logic [core_fetch_pkg::FBUF_BYTES/2-1:0]    fill_err;
    logic [core_fetch_pkg::FBUF_BYTES/2-1:0]    n_e_buf;

    assign data_out  = d_buf[core_fetch_pkg::FD_IBUF_R:0];
    assign error_out = e_buf[core_fetch_pkg::FD_ERR_R:0];

    // ----------------------------------------
    // Fill selection.
    // ----------------------------------------

    always_comb begin
        fill_bytes = '0;
        fill_data  = '0;
        fill_err   = '0;
        if (fill_en) begin
            if (fill_8) begin
                fill_bytes      = 5'd8;
                fill_data[63:0] = data_in[63:0];
                fill_err[3:0]   = {4{error_in}};
            end else if (fill_6) begin
                fill_bytes      = 5'd6;
                fill_data[47:0] = data_in[47:0];
                fill_err[2:0]   = {3{error_in}};
            end else if (fill_4) begin
                fill_bytes      = 5'd4;
                fill_data[31:0] = data_in[31:0];
                fill_err[1:0]   = {2{error_in}};
            end else if (fill_2) begin
                fill_bytes      = 5'd2;
                fill_data[15:0] = data_in[15:0];
                fill_err[0]     = error_in;
            end
        end
    end

    // ----------------------------------------
    // Depth and shifting.
    // ----------------------------------------

    assign drain_bytes = drain_4 ? 5'd4 : (drain_2 ? 5'd2 : 5'd0);
    assign shf_up      = depth - drain_bytes;   // Depth left after the drain.
    assign n_depth     = flush ? '0 : depth + fill_bytes - drain_bytes;

    // Old bytes move down, new bytes are ORed in on top of them.
    assign n_d_buf = (d_buf >> {drain_bytes, 3'b000}) | (fill_data << {shf_up, 3'b000});
    assign n_e_buf = (e_buf >> drain_bytes[4:1]) | (fill_err << shf_up[4:1]);

    // The OR fill needs empty bytes to be zero, so flush clears the store.
    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush) begin
            depth <= '0;
            d_buf <= '0;
            e_buf <= '0;
        end else begin
            depth <= n_depth;
            d_buf <= n_d_buf;
            e_buf <= n_e_buf;
        end
    end

    // ----------------------------------------
    // Checks on the neighbouring stages.
    // ----------------------------------------

    a_depth_cap: assert property (@(posedge g_clk) disable iff (!g_resetn)
        depth <= core_fetch_pkg::FBUF_BYTES);       // Request stage flow control.

    a_drain_onehot: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(drain_2 && drain_4));

    a_drain_depth: assert property (@(posedge g_clk) disable iff (!g_resetn)
        drain_bytes <= depth);                      // Decode drains only what it sees.

endmodule

//--- hw/core_pipe_decode_len.sv
// Length decode stage. Captures one instruction per cycle at most; while
// decode_stall is high the registered output holds and nothing drains.
`timescale 1ns/1ps

module core_pipe_decode_len (
    input  logic                                          g_clk,
    input  logic                                          g_resetn,
    input  logic                                          redirect,
    input  core_fetch_pkg::core_addr_t                    redirect_pc,
    input  logic [core_fetch_pkg::FBUF_DEPTH_W-1:0]       depth,
    input  logic [31:0]                                   data_out,    // Buffer head.
    input  logic [1:0]                                    error_out,   // Head tags.
    output logic                                          drain_2,
    output logic                                          drain_4,
    input  logic                                          decode_stall,
    output logic                                          instr_valid,
    output core_instr_pkg::instr_t                        instr,
    output core_fetch_pkg::core_addr_t                    instr_pc,
    output core_instr_pkg::ilen_t                         instr_len,
    output logic                                          instr_error
);

    logic                       is_32;      // Head is a full-width instruction.
    logic                       have_instr; // Enough bytes for it.
    logic                       capture;
    core_fetch_pkg::core_addr_t pc_q;       // PC of the buffer head.

    assign is_32      = data_out[1:0] == core_instr_pkg::RVC_FULL_OP;
    assign have_instr = is_32 ? (depth >= 5'd4) : (depth >= 5'd2);
    assign capture    = have_instr && !decode_stall && !redirect;

    assign drain_2 = capture && !is_32;     // Same edge as the capture.
    assign drain_4 = capture && is_32;

    // ----------------------------------------
    // Control.
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            instr_valid <= 1'b0;
            pc_q        <= core_fetch_pkg::RESET_PC;
        end else if (redirect) begin
            instr_valid <= 1'b0;        // Drop whatever was waiting.
            pc_q        <= redirect_pc;
        end else if (!decode_stall) begin
            instr_valid <= have_instr;
            if (have_instr) begin
                pc_q <= pc_q + (is_32 ? 32'd4 : 32'd2);
            end
        end
    end

    // Payload.
    always_ff @(posedge g_clk) begin
        if (capture) begin
            instr       <= is_32 ? data_out : {16'h0000, data_out[15:0]};
            instr_pc    <= pc_q;
            instr_len   <= is_32 ? core_instr_pkg::ILEN_32 : core_instr_pkg::ILEN_16;
            instr_error <= is_32 ? (|error_out) : error_out[0]; // Covered halfwords only.
        end
    end

    // Downstream may rely on a stalled output not changing.
    a_stall_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (instr_valid && decode_stall && !redirect) |=>
            (instr_valid && $stable(instr) && $stable(instr_pc) &&
             $stable(instr_len) && $stable(instr_error)));

endmodule

//--- hw/core_pipe_frontend.sv
// Fetch front end top. Memory must answer with one-cycle latency and no stall.
// First instruction appears three edges after a redirect or reset release.
`timescale 1ns/1ps

module core_pipe_frontend (
    input  logic                                          g_clk,
    input  logic                                          g_resetn,
    input  logic                                          redirect,
    input  core_fetch_pkg::core_addr_t                    redirect_pc,
    output logic                                          mem_req,
    output core_fetch_pkg::core_addr_t                    mem_addr,
    input  logic                                          mem_rvalid,
    input  logic [8*core_fetch_pkg::FETCH_BYTES-1:0]      mem_rdata,
    input  logic                                          mem_rerr,
    output logic                                          instr_valid,
    output core_instr_pkg::instr_t                        instr,
    output core_fetch_pkg::core_addr_t                    instr_pc,
    output core_instr_pkg::ilen_t                         instr_len,
    output logic                                          instr_error,
    input  logic                                          decode_stall
);

    // ----------------------------------------
    // Stage links.
    // ----------------------------------------

    logic [core_fetch_pkg::FBUF_DEPTH_W-1:0]  depth;
    logic [core_fetch_pkg::FBUF_DEPTH_W-1:0]  n_depth;
    logic                                     fill_en;
    logic                                     fill_2;
    logic                                     fill_4;
    logic                                     fill_6;
    logic                                     fill_8;
    logic                                     error_in;
    logic [8*core_fetch_pkg::FETCH_BYTES-1:0] data_in;
    logic [core_fetch_pkg::FD_IBUF_R:0]       data_out;
    logic [core_fetch_pkg::FD_ERR_R:0]        error_out;
    logic                                     drain_2;
    logic                                     drain_4;

    core_pipe_fetch_req u_fetch_req (           // Stage 1.
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .n_depth     (n_depth),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_rvalid  (mem_rvalid),
        .mem_rerr    (mem_rerr),
        .mem_rdata   (mem_rdata),
        .fill_en     (fill_en),
        .fill_2      (fill_2),
        .fill_4      (fill_4),
        .fill_6      (fill_6),
        .fill_8      (fill_8),
        .error_in    (error_in),
        .data_in     (data_in)
    );

    core_pipe_fetch_buffer u_fetch_buffer (     // Stage 2, flushed by redirect.
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .flush     (redirect),
        .depth     (depth),
        .n_depth   (n_depth),
        .fill_en   (fill_en),
        .error_in  (error_in),
        .fill_2    (fill_2),
        .fill_4    (fill_4),
        .fill_6    (fill_6),
        .fill_8    (fill_8),
        .data_in   (data_in),
        .data_out  (data_out),
        .error_out (error_out),
        .drain_2   (drain_2),
        .drain_4   (drain_4)
    );

    core_pipe_decode_len u_decode_len (         // Stage 3.
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .depth        (depth),
        .data_out     (data_out),
        .error_out    (error_out),
        .drain_2      (drain_2),
        .drain_4      (drain_4),
        .decode_stall (decode_stall),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .instr_len    (instr_len),
        .instr_error  (instr_error)
    );

endmodule

//--- verification/tb_core_frontend.sv
// Testbench for the fetch front end. Memory is 256 words and wraps on mem_addr[10:3].
// Stimulus is driven 1 ns after each rising edge; outputs are sampled on the falling edge.
`timescale 1ns/1ps

module tb_core_frontend;

    localparam int MEM_WORDS = 256;

    logic                        g_clk;
    logic                        g_resetn;
    logic                        redirect;
    core_fetch_pkg::core_addr_t  redirect_pc;
    logic                        mem_req;
    core_fetch_pkg::core_addr_t  mem_addr;
    logic                        mem_rvalid;
    logic [63:0]                 mem_rdata;
    logic                        mem_rerr;
    logic                        instr_valid;
    core_instr_pkg::instr_t      instr;
    core_fetch_pkg::core_addr_t  instr_pc;
    core_instr_pkg::ilen_t       instr_len;
    logic                        instr_error;
    logic                        decode_stall;

    logic [63:0] mem [0:MEM_WORDS-1];       // Instruction memory.
    logic        mem_err [0:MEM_WORDS-1];   // One fetch-error flag per word.
    integer      seed;
    logic        stall_en;                  // Enables random back-pressure.
    int          accepted = 0;              // Instructions taken downstream.
    int          mismatches = 0;
    int          other_errors = 0;
    int          timeouts = 0;
    int          cross_count = 0;           // 32-bit instructions over a word edge.
    int          err_count = 0;
    int          clean_count = 0;

    core_pipe_frontend dut (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata),
        .mem_rerr     (mem_rerr),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .instr_len    (instr_len),
        .instr_error  (instr_error),
        .decode_stall (decode_stall)
    );

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;  // 8 ns period.
    end

    // ----------------------------------------
    // Memory contents and reference model.
    // ----------------------------------------

    task automatic fill_memory();
        int          i;
        int          h;
        logic [31:0] r;
        logic [15:0] hw;
        for (i = 0; i < MEM_WORDS; i++) begin
            for (h = 0; h < 4; h++) begin
                r  = $random(seed);
                hw = r[15:0];
                if (r[16]) hw[1:0] = 2'b11;     // Bias toward 32-bit starts.
                mem[i][16*h +: 16] = hw;
            end
            r          = $random(seed);
            mem_err[i] = (r[2:0] == 3'd0);      // About one word in eight.
        end
    endtask

    function automatic logic [15:0] halfword_at(input core_fetch_pkg::core_addr_t a);
        logic [63:0] w;
        w = mem[a[10:3]];
        return w[16*a[2:1] +: 16];
    endfunction

    // Expected instruction at pc: length from the low opcode bits, error from every word used.
    function automatic void expected_instr(input core_fetch_pkg::core_addr_t pc,
                                           output core_instr_pkg::instr_t i,
                                           output core_instr_pkg::ilen_t len,
                                           output logic err);
        logic [15:0]                lo;
        logic [15:0]                hi;
        core_fetch_pkg::core_addr_t pc_hi;
        pc_hi = pc + 32'd2;
        lo    = halfword_at(pc);
        hi    = halfword_at(pc_hi);
        if (lo[1:0] == core_instr_pkg::RVC_FULL_OP) begin
            i   = {hi, lo};
            len = core_instr_pkg::ILEN_32;
            err = mem_err[pc[10:3]] | mem_err[pc_hi[10:3]];
        end else begin
            i   = {16'h0000, lo};             // Compressed, zero-extended.
            len = core_instr_pkg::ILEN_16;
            err = mem_err[pc[10:3]];
        end
    endfunction

    // Edges from the sampling edge to the first instr_valid.
    // A 32-bit start in the last halfword of a word needs a second read.
    function automatic int start_edges(input core_fetch_pkg::core_addr_t pc);
        logic [15:0] lo;
        lo = halfword_at(pc);
        if (pc[2:1] == 2'd3 && lo[1:0] == core_instr_pkg::RVC_FULL_OP) begin
            return 4;
        end else begin
            return 3;
        end
    endfunction

    // ----------------------------------------
    // Compare tasks.
    // ----------------------------------------

    task automatic check_instr(input string name, input core_instr_pkg::instr_t got,
                               input core_instr_pkg::instr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input core_fetch_pkg::core_addr_t got,
                              input core_fetch_pkg::core_addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input core_instr_pkg::ilen_t got,
                             input core_instr_pkg::ilen_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %s expected %s", $time, name,
                     got.name(), exp.name());
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ----------------------------------------
    // Memory model and back-pressure.
    // ----------------------------------------

    initial begin : memory_model
        logic                       req_s;
        core_fetch_pkg::core_addr_t addr_s;
        core_fetch_pkg::core_addr_t fetch_pc;   // Next aligned read address.
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        mem_rerr   = 1'b0;
        fetch_pc   = {core_fetch_pkg::RESET_PC[31:3], 3'b000};
        forever begin
            @(negedge g_clk);
            req_s  = mem_req;                   // Request seen by the next edge.
            addr_s = mem_addr;
            if (!g_resetn) begin
                fetch_pc = {core_fetch_pkg::RESET_PC[31:3], 3'b000};
            end else if (redirect) begin
                check_flag("mem_req", req_s, 1'b0);   // No read in a redirect cycle.
                fetch_pc = {redirect_pc[31:3], 3'b000};
            end else if (req_s) begin
                check_addr("mem_addr", addr_s, fetch_pc);
                fetch_pc = fetch_pc + 32'd8;
            end
            @(posedge g_clk);
            #1;
            mem_rvalid = req_s;                 // Answer in the following cycle.
            mem_rdata  = req_s ? mem[addr_s[10:3]] : '0;
            mem_rerr   = req_s && mem_err[addr_s[10:3]];
        end
    end

    initial begin : stall_drive
        logic [31:0] r;
        decode_stall = 1'b0;
        forever begin
            @(posedge g_clk);
            #1;
            if (stall_en) begin
                r            = $random(seed);
                decode_stall = r[0];
            end else begin
                decode_stall = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Compare process.
    // ----------------------------------------

    initial begin : compare
        core_instr_pkg::instr_t     e_instr;
        core_instr_pkg::ilen_t      e_len;
        logic                       e_err;
        core_fetch_pkg::core_addr_t exp_pc;
        logic                       held_valid;
        core_instr_pkg::instr_t     held_instr;
        core_fetch_pkg::core_addr_t held_pc;
        core_instr_pkg::ilen_t      held_len;
        logic                       held_err;
        exp_pc     = core_fetch_pkg::RESET_PC;
        held_valid = 1'b0;
        forever begin
            @(negedge g_clk);
            if (!g_resetn) begin
                exp_pc     = core_fetch_pkg::RESET_PC;
                held_valid = 1'b0;
            end else begin
                if (held_valid) begin           // Stalled last cycle, must not move.
                    check_flag("instr_valid held", instr_valid, 1'b1);
                    check_instr("instr held", instr, held_instr);
                    check_addr("instr_pc held", instr_pc, held_pc);
                    check_len("instr_len held", instr_len, held_len);
                    check_flag("instr_error held", instr_error, held_err);
                end
                if (instr_valid && !decode_stall) begin
                    expected_instr(exp_pc, e_instr, e_len, e_err);
                    check_instr("instr", instr, e_instr);
                    check_addr("instr_pc", instr_pc, exp_pc);
                    check_len("instr_len", instr_len, e_len);
                    check_flag("instr_error", instr_error, e_err);
                    if (e_len == core_instr_pkg::ILEN_32 && exp_pc[2:1] == 2'd3) cross_count++;
                    if (e_err) err_count++;
                    else clean_count++;
                    exp_pc = exp_pc + ((e_len == core_instr_pkg::ILEN_32) ? 32'd4 : 32'd2);
                    accepted++;
                end
                held_valid = instr_valid && decode_stall && !redirect;
                held_instr = instr;
                held_pc    = instr_pc;
                held_len   = instr_len;
                held_err   = instr_error;
                if (redirect) exp_pc = redirect_pc;  // New stream starts at the target.
            end
        end
    end

    // ----------------------------------------
    // Waits and stimulus.
    // ----------------------------------------

    task automatic wait_accepted(input int target, input int max_cycles, input string what);
        int cycles;
        cycles = 0;
        while (accepted < target && cycles < max_cycles) begin
            @(posedge g_clk);
            cycles++;
        end
        if (accepted < target) begin
            timeouts++;
            $display("Timeout at %0t: %s, only %0d of %0d instructions arrived",
                     $time, what, accepted, target);
        end
    endtask

    // Call right after the edge that sampled the release or the redirect.
    task automatic count_start_edges(input string what, input int exp_edges);
        int edges;
        edges = 0;
        do begin
            @(posedge g_clk);
            edges++;
            @(negedge g_clk);
        end while (!instr_valid && edges < 10);
        if (!instr_valid) begin
            timeouts++;
            $display("Timeout at %0t: no instruction within 10 edges after %s", $time, what);
        end else if (edges != exp_edges) begin
            other_errors++;
            $display("First instruction after %s came %0d edges later instead of %0d",
                     what, edges, exp_edges);
        end
    endtask

    initial begin : stimulus
        int                         k;
        logic [31:0]                r;
        core_fetch_pkg::core_addr_t target;
        seed        = 32'h537517ce;
        g_resetn    = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall_en    = 1'b0;
        fill_memory();
        repeat (3) @(posedge g_clk);
        #1 g_resetn = 1'b1;
        @(posedge g_clk);                       // Edge that samples the release.
        count_start_edges("reset release", start_edges(core_fetch_pkg::RESET_PC));
        if (timeouts == 0) wait_accepted(40, 400, "stream after reset");
        for (k = 0; k < 8 && timeouts == 0; k++) begin
            repeat (2 + k) @(posedge g_clk);
            r           = $random(seed);
            target      = '0;
            target[10:3] = r[10:3];
            target[2:1] = k[1:0];               // Offsets 0, 2, 4, 6 in turn.
            #1;
            redirect    = 1'b1;
            redirect_pc = target;
            @(posedge g_clk);
            #1 redirect = 1'b0;
            count_start_edges("redirect", start_edges(target));
            if (timeouts == 0) wait_accepted(accepted + 6, 100, "stream after redirect");
        end
        if (timeouts == 0) begin
            stall_en = 1'b1;
            wait_accepted(accepted + 150, 2000, "stream under random stall");
            stall_en = 1'b0;
        end
        if (timeouts == 0 && cross_count == 0) begin
            other_errors++;
            $display("No 32-bit instruction crossing a word boundary was checked");
        end
        if (timeouts == 0 && (err_count == 0 || clean_count == 0)) begin
            other_errors++;
            $display("Errored and clean instructions were not both checked");
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d timeouts",
                 mismatches, other_errors, timeouts);
        if (mismatches + other_errors + timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- build.f
hw/core_fetch_pkg.sv
hw/core_instr_pkg.sv
hw/core_pipe_fetch_req.sv
hw/core_pipe_fetch_buffer.sv
hw/core_pipe_decode_len.sv
hw/core_pipe_frontend.sv
verification/tb_core_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_core_frontend -f build.f -o sim_tb_core_frontend

./obj_dir/sim_tb_core_frontend | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1
